// ==== common/video_pkg.sv ====
package video_pkg;

    // horizontal timing in pixel clocks
    localparam int H_SYNC            = 118;
    localparam int H_BACK_PORCH      = 152;
    localparam int H_ACTIVE          = 1280;
    localparam int H_FRONT_PORCH     = 38;
    localparam int H_TOTAL           = H_SYNC + H_BACK_PORCH + H_ACTIVE + H_FRONT_PORCH;
    localparam int H_HALF            = H_TOTAL / 2;
    localparam int H_ACT_FIRST       = H_SYNC + H_BACK_PORCH;
    localparam int H_VSYNC_PULSE_LEN = 678;
    localparam int H_EQ_PULSE_LEN    = 58;
    localparam int H_BURST_START     = 132;
    localparam int H_BURST_END       = 196;

    // vertical timing in half-lines
    localparam int V_TOTAL       = 1050;
    localparam int V_FIELD0_LAST = 524;
    localparam int V_SYNC0_FIRST = 6;
    localparam int V_SYNC1_FIRST = 531;
    localparam int V_BLOCK_LEN   = 6;
    localparam int V_ACT0_FIRST  = 42;
    localparam int V_ACT0_LAST   = 521;
    localparam int V_ACT1_FIRST  = 568;
    localparam int V_ACT1_LAST   = 1047;

    // widths and sizes
    localparam int HCNT_W      = 11;
    localparam int VCNT_W      = 11;
    localparam int FLINE_W     = 9;
    localparam int PIX_DIV     = 4;
    localparam int PIX_PHASE_W = 2;
    localparam int LINE_PIXELS = 320;
    localparam int PIX_ADDR_W  = 9;
    localparam int PAL_ENTRIES = 16;
    localparam int PAL_ADDR_W  = 4;
    localparam int RGB_W       = 4;
    localparam int LEVEL_W     = 6;

    // output levels
    localparam int LUMA_SYNC   = 0;
    localparam int LUMA_BLANK  = 16;
    localparam int CHROMA_ZERO = 32;
    localparam int BURST_AMP   = 8;

    // 227.5 subcarrier cycles per line: round(227.5 * 2^16 / H_TOTAL)
    localparam int SC_PHASE_W = 16;
    localparam int SC_STEP    = 9389;

endpackage

// ==== video_composite/video_modulator.sv ====
`timescale 1ns/1ps

module video_modulator (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [video_pkg::RGB_W-1:0]   r,
    input  logic [video_pkg::RGB_W-1:0]   g,
    input  logic [video_pkg::RGB_W-1:0]   b,
    input  logic                          color_burst,
    input  logic                          active,
    input  logic                          sync_n_in,
    output logic [video_pkg::LEVEL_W-1:0] luma,
    output logic [video_pkg::LEVEL_W-1:0] chroma
);
    import video_pkg::*;

    // 16-step sine scaled to +-8
    function automatic logic signed [4:0] sine16(input logic [3:0] idx);
        logic signed [4:0] s;
        case (idx)
            4'd0:    s = 5'sd0;
            4'd1:    s = 5'sd3;
            4'd2:    s = 5'sd6;
            4'd3:    s = 5'sd7;
            4'd4:    s = 5'sd8;
            4'd5:    s = 5'sd7;
            4'd6:    s = 5'sd6;
            4'd7:    s = 5'sd3;
            4'd8:    s = 5'sd0;
            4'd9:    s = -5'sd3;
            4'd10:   s = -5'sd6;
            4'd11:   s = -5'sd7;
            4'd12:   s = -5'sd8;
            4'd13:   s = -5'sd7;
            4'd14:   s = -5'sd6;
            default: s = -5'sd3;
        endcase
        return s;
    endfunction

    logic [SC_PHASE_W-1:0] sc_phase;
    logic [3:0]            sc_idx;
    logic signed [4:0]     sin_v;
    logic signed [4:0]     cos_v;
    logic [7:0]            y_sum;
    logic signed [5:0]     u_diff;
    logic signed [5:0]     v_diff;
    logic signed [11:0]    mix;
    logic signed [11:0]    burst_offs;
    logic [LEVEL_W-1:0]    luma_d;
    logic [LEVEL_W-1:0]    chroma_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sc_phase <= '0;
        end else begin
            sc_phase <= sc_phase + SC_PHASE_W'(SC_STEP);
        end
    end

    assign sc_idx = sc_phase[SC_PHASE_W-1 -: 4];
    assign sin_v  = sine16(sc_idx);
    assign cos_v  = sine16(sc_idx + 4'd4);

    always_comb begin
        // weighted luma, max 120
        y_sum  = 8'(r) * 8'd2 + 8'(g) * 8'd5 + 8'(b);
        u_diff = $signed({2'b00, b}) - $signed({2'b00, y_sum[6:3]});
        v_diff = $signed({2'b00, r}) - $signed({2'b00, y_sum[6:3]});
        mix    = u_diff * sin_v + v_diff * cos_v;
        burst_offs = 12'(BURST_AMP * sin_v);

        if (!sync_n_in) begin
            luma_d = LEVEL_W'(LUMA_SYNC);
        end else if (!active) begin
            luma_d = LEVEL_W'(LUMA_BLANK);
        end else begin
            luma_d = LEVEL_W'(LUMA_BLANK + (y_sum >> 2));
        end

        // burst sits on the -U axis
        if (color_burst) begin
            chroma_d = LEVEL_W'(CHROMA_ZERO - (burst_offs >>> 3));
        end else if (active) begin
            chroma_d = LEVEL_W'(CHROMA_ZERO + (mix >>> 3));
        end else begin
            chroma_d = LEVEL_W'(CHROMA_ZERO);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            luma   <= LEVEL_W'(LUMA_SYNC);
            chroma <= LEVEL_W'(CHROMA_ZERO);
        end else begin
            luma   <= luma_d;
            chroma <= chroma_d;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(active && color_burst));

endmodule

// ==== video_composite/video_composite.sv ====
`timescale 1ns/1ps

module video_composite (
    input  logic                            rst,
    input  logic                            clk,
    input  logic [3*video_pkg::RGB_W-1:0]   palette_rgb_data,

    output logic                            next_frame,
    output logic                            next_line,
    output logic                            next_pixel,
    output logic                            vblank_pulse,
    output logic                            current_field,

    output logic [video_pkg::LEVEL_W-1:0]   luma,
    output logic [video_pkg::LEVEL_W-1:0]   chroma,

    output logic [video_pkg::RGB_W-1:0]     rgb_r,
    output logic [video_pkg::RGB_W-1:0]     rgb_g,
    output logic [video_pkg::RGB_W-1:0]     rgb_b,
    output logic                            rgb_sync_n
);
    import video_pkg::*;

    logic [HCNT_W-1:0]  hcnt;
    logic [VCNT_W-1:0]  vcnt;
    logic [FLINE_W-1:0] field_line_cnt;
    logic               field;
    logic               next_frame_r;
    logic               current_field_r;
    logic               mod_sync_n;

    // horizontal windows
    logic h_hsync_pulse;
    logic h_vsync_pulse;
    logic h_eq_pulse;
    logic h_burst;
    logic h_active;
    logic h_last;
    logic h_half_last;

    assign h_hsync_pulse = (hcnt < H_SYNC);
    assign h_vsync_pulse = (hcnt < H_VSYNC_PULSE_LEN) ||
                           (hcnt >= H_HALF && hcnt < H_HALF + H_VSYNC_PULSE_LEN);
    assign h_eq_pulse    = (hcnt < H_EQ_PULSE_LEN) ||
                           (hcnt >= H_HALF && hcnt < H_HALF + H_EQ_PULSE_LEN);
    assign h_burst       = (hcnt >= H_BURST_START && hcnt < H_BURST_END);
    assign h_active      = (hcnt >= H_ACT_FIRST && hcnt < H_ACT_FIRST + H_ACTIVE);
    assign h_last        = (hcnt == H_TOTAL - 1);
    assign h_half_last   = (hcnt == H_HALF - 1) || h_last;

    // vertical regions, each sync block framed by an equalisation block on both sides
    logic v_sync;
    logic v_eq;
    logic v_active;
    logic v_pre_active;
    logic v_last;
    logic v_field0_last;

    assign v_sync = (vcnt >= V_SYNC0_FIRST && vcnt < V_SYNC0_FIRST + V_BLOCK_LEN) ||
                    (vcnt >= V_SYNC1_FIRST && vcnt < V_SYNC1_FIRST + V_BLOCK_LEN);

    assign v_eq =
        (vcnt >= V_SYNC0_FIRST - V_BLOCK_LEN && vcnt < V_SYNC0_FIRST) ||
        (vcnt >= V_SYNC0_FIRST + V_BLOCK_LEN && vcnt < V_SYNC0_FIRST + 2 * V_BLOCK_LEN) ||
        (vcnt >= V_SYNC1_FIRST - V_BLOCK_LEN && vcnt < V_SYNC1_FIRST) ||
        (vcnt >= V_SYNC1_FIRST + V_BLOCK_LEN && vcnt < V_SYNC1_FIRST + 2 * V_BLOCK_LEN);

    assign v_active = (vcnt >= V_ACT0_FIRST && vcnt <= V_ACT0_LAST) ||
                      (vcnt >= V_ACT1_FIRST && vcnt <= V_ACT1_LAST);

    // half-line just before the first active line of a field
    assign v_pre_active  = (vcnt == V_ACT0_FIRST - 1) || (vcnt == V_ACT1_FIRST - 1);
    assign v_last        = (vcnt == V_TOTAL - 1);
    assign v_field0_last = (vcnt == V_FIELD0_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            hcnt <= h_last ? '0 : hcnt + 1'b1;
            if (h_half_last) begin
                vcnt <= v_last ? '0 : vcnt + 1'b1;
            end
        end
    end

    // field parity and line count within the field
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            field          <= 1'b0;
            field_line_cnt <= '0;
        end else if (h_half_last && v_last) begin
            field          <= 1'b0;
            field_line_cnt <= '0;
        end else if (h_half_last && v_field0_last) begin
            field          <= 1'b1;
            field_line_cnt <= '0;
        end else if (h_last) begin
            field_line_cnt <= field_line_cnt + 1'b1;
        end
    end

    // arm at end of the pre-active line, fire with the next line strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            next_frame_r    <= 1'b0;
            current_field_r <= 1'b0;
        end else if (h_last && v_pre_active) begin
            next_frame_r    <= 1'b1;
            current_field_r <= field;
        end else if (next_line) begin
            next_frame_r    <= 1'b0;
        end
    end

    assign next_line     = (hcnt == H_ACT_FIRST - 1);
    assign next_pixel    = h_active;
    assign next_frame    = next_frame_r && next_line;
    assign current_field = current_field_r;
    assign vblank_pulse  = h_half_last && (v_field0_last || v_last);

    always_comb begin
        if (v_sync) begin
            mod_sync_n = !h_vsync_pulse;
        end else if (v_eq) begin
            mod_sync_n = !h_eq_pulse;
        end else begin
            mod_sync_n = !h_hsync_pulse;
        end
    end

    assign rgb_r      = palette_rgb_data[3*RGB_W-1:2*RGB_W];
    assign rgb_g      = palette_rgb_data[2*RGB_W-1:RGB_W];
    assign rgb_b      = palette_rgb_data[RGB_W-1:0];
    assign rgb_sync_n = mod_sync_n;

    video_modulator u_modulator (
        .clk         (clk),
        .rst         (rst),
        .r           (rgb_r),
        .g           (rgb_g),
        .b           (rgb_b),
        .color_burst (v_active && h_burst),
        .active      (v_active && h_active),
        .sync_n_in   (mod_sync_n),
        .luma        (luma),
        .chroma      (chroma)
    );

    assert property (@(posedge clk) disable iff (rst) hcnt < H_TOTAL);
    assert property (@(posedge clk) disable iff (rst) vcnt < V_TOTAL);

    // both fields hold the same number of full-line ends
    assert property (@(posedge clk) disable iff (rst)
        vblank_pulse |-> field_line_cnt == FLINE_W'(V_FIELD0_LAST / 2));

endmodule

// ==== source/video_line_fetch.sv ====
`timescale 1ns/1ps

module video_line_fetch (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                buf_wr_en,
    input  logic [video_pkg::PIX_ADDR_W-1:0]    buf_wr_addr,
    input  logic [video_pkg::PAL_ADDR_W-1:0]    buf_wr_index,
    input  logic                                pal_wr_en,
    input  logic [video_pkg::PAL_ADDR_W-1:0]    pal_wr_addr,
    input  logic [3*video_pkg::RGB_W-1:0]       pal_wr_data,
    input  logic                                next_line,
    input  logic                                next_pixel,
    output logic [3*video_pkg::RGB_W-1:0]       palette_rgb_data
);
    import video_pkg::*;

    logic [PAL_ADDR_W-1:0]  index_mem [LINE_PIXELS];
    logic [3*RGB_W-1:0]     pal_mem   [PAL_ENTRIES];
    logic [PIX_ADDR_W-1:0]  col;
    logic [PIX_PHASE_W-1:0] phase;

    always_ff @(posedge clk) begin
        if (buf_wr_en) begin
            index_mem[buf_wr_addr] <= buf_wr_index;
        end
        if (pal_wr_en) begin
            pal_mem[pal_wr_addr] <= pal_wr_data;
        end
    end

    // column walk, PIX_DIV clocks per stored pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col   <= '0;
            phase <= '0;
        end else if (next_line) begin
            col   <= '0;
            phase <= '0;
        end else if (next_pixel) begin
            phase <= phase + 1'b1;
            if (phase == PIX_PHASE_W'(PIX_DIV - 1)) begin
                col <= col + 1'b1;
            end
        end
    end

    // palette lookup, blank outside the pixel window
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            palette_rgb_data <= '0;
        end else if (next_pixel) begin
            palette_rgb_data <= pal_mem[index_mem[col]];
        end else begin
            palette_rgb_data <= '0;
        end
    end

    // pixel window must not outrun the stored line
    assert property (@(posedge clk) disable iff (rst) next_pixel |-> col < LINE_PIXELS);

endmodule

// ==== source/video_top.sv ====
`timescale 1ns/1ps

module video_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             buf_wr_en,
    input  logic [video_pkg::PIX_ADDR_W-1:0] buf_wr_addr,
    input  logic [video_pkg::PAL_ADDR_W-1:0] buf_wr_index,
    input  logic                             pal_wr_en,
    input  logic [video_pkg::PAL_ADDR_W-1:0] pal_wr_addr,
    input  logic [3*video_pkg::RGB_W-1:0]    pal_wr_data,
    output logic                             next_frame,
    output logic                             next_line,
    output logic                             next_pixel,
    output logic                             vblank_pulse,
    output logic                             current_field,
    output logic [video_pkg::LEVEL_W-1:0]    luma,
    output logic [video_pkg::LEVEL_W-1:0]    chroma,
    output logic [video_pkg::RGB_W-1:0]      rgb_r,
    output logic [video_pkg::RGB_W-1:0]      rgb_g,
    output logic [video_pkg::RGB_W-1:0]      rgb_b,
    output logic                             rgb_sync_n
);
    import video_pkg::*;

    // registered palette colour from fetch to timing block
    logic [3*RGB_W-1:0] palette_rgb_data;

    video_line_fetch u_fetch (
        .clk              (clk),
        .rst              (rst),
        .buf_wr_en        (buf_wr_en),
        .buf_wr_addr      (buf_wr_addr),
        .buf_wr_index     (buf_wr_index),
        .pal_wr_en        (pal_wr_en),
        .pal_wr_addr      (pal_wr_addr),
        .pal_wr_data      (pal_wr_data),
        .next_line        (next_line),
        .next_pixel       (next_pixel),
        .palette_rgb_data (palette_rgb_data)
    );

    video_composite u_composite (
        .rst              (rst),
        .clk              (clk),
        .palette_rgb_data (palette_rgb_data),
        .next_frame       (next_frame),
        .next_line        (next_line),
        .next_pixel       (next_pixel),
        .vblank_pulse     (vblank_pulse),
        .current_field    (current_field),
        .luma             (luma),
        .chroma           (chroma),
        .rgb_r            (rgb_r),
        .rgb_g            (rgb_g),
        .rgb_b            (rgb_b),
        .rgb_sync_n       (rgb_sync_n)
    );

endmodule

// ==== testbench/tb_video_top.sv ====
`timescale 1ns/1ps

module tb_video_top;
    import video_pkg::*;

    localparam int FIELD_CLKS     = (V_TOTAL / 2) * H_HALF;
    localparam int TIMEOUT_CYCLES = 2 * (V_TOTAL / 2) * H_TOTAL + 5000;
    localparam int T_LINE   = 0;
    localparam int T_FIELD  = 1;
    localparam int T_SYNC   = 2;
    localparam int T_PIXEL  = 3;
    localparam int T_LUMA   = 4;
    localparam int T_CHROMA = 5;
    localparam int N_TESTS  = 6;

    logic                   clk;
    logic                   rst;
    logic                   buf_wr_en;
    logic [PIX_ADDR_W-1:0]  buf_wr_addr;
    logic [PAL_ADDR_W-1:0]  buf_wr_index;
    logic                   pal_wr_en;
    logic [PAL_ADDR_W-1:0]  pal_wr_addr;
    logic [3*RGB_W-1:0]     pal_wr_data;
    logic                   next_frame;
    logic                   next_line;
    logic                   next_pixel;
    logic                   vblank_pulse;
    logic                   current_field;
    logic [LEVEL_W-1:0]     luma;
    logic [LEVEL_W-1:0]     chroma;
    logic [RGB_W-1:0]       rgb_r;
    logic [RGB_W-1:0]       rgb_g;
    logic [RGB_W-1:0]       rgb_b;
    logic                   rgb_sync_n;

    integer              seed;
    int                  errs [N_TESTS];
    int                  cycles;
    logic                frame_en;
    logic [3*RGB_W-1:0]  tb_pal [PAL_ENTRIES];
    logic [PAL_ADDR_W-1:0] tb_idx [LINE_PIXELS];

    // reference position and strobe history
    int   ref_h;
    int   ref_v;
    int   since_line;
    int   since_vb;
    int   nf_between;
    int   vb_count;
    int   nf_count;
    logic last_field;

    logic               in_sync_blk;
    logic               in_act_blk;
    logic               vid_active;
    logic               burst_win;
    logic               exp_sync_n;
    logic [3*RGB_W-1:0] exp_rgb;
    int                 exp_luma;
    logic               chroma_busy_d;

    video_top u_video_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string test_name(input int id);
        case (id)
            T_LINE:  return "line_period";
            T_FIELD: return "field_sequence";
            T_SYNC:  return "sync_shape";
            T_PIXEL: return "pixel_data";
            T_LUMA:  return "luma_levels";
            default: return "chroma_rest";
        endcase
    endfunction

    function automatic int luma_level(input logic sync_n, input logic act,
                                      input int r, input int g, input int b);
        if (!sync_n) begin
            return LUMA_SYNC;
        end
        if (!act) begin
            return LUMA_BLANK;
        end
        return LUMA_BLANK + ((2 * r + 5 * g + b) >> 2);
    endfunction

    task automatic note_mismatch(input int id, input int exp, input int act);
        errs[id]++;
        if (errs[id] <= 5) begin
            $display("mismatch %s: expected %0d actual %0d at %0t",
                     test_name(id), exp, act, $time);
        end
    endtask

    task automatic report_test(input int id);
        if (errs[id] == 0) begin
            $display("%s: pass", test_name(id));
        end else begin
            $display("%s: fail, %0d errors", test_name(id), errs[id]);
        end
    endtask

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ref_h      <= 0;
            ref_v      <= 0;
            since_line <= 0;
            since_vb   <= 0;
            nf_between <= 0;
            vb_count   <= 0;
            nf_count   <= 0;
            last_field <= 1'b0;
        end else begin
            ref_h <= (ref_h == H_TOTAL - 1) ? 0 : ref_h + 1;
            if (ref_h == H_HALF - 1 || ref_h == H_TOTAL - 1) begin
                ref_v <= (ref_v == V_TOTAL - 1) ? 0 : ref_v + 1;
            end
            since_line <= next_line ? 1 : since_line + 1;
            since_vb   <= vblank_pulse ? 1 : since_vb + 1;
            nf_between <= vblank_pulse ? 0 : nf_between + int'(next_frame);
            vb_count   <= vb_count + int'(vblank_pulse);
            if (next_frame) begin
                nf_count   <= nf_count + 1;
                last_field <= current_field;
            end
        end
    end

    always_comb begin
        in_sync_blk = (ref_v >= V_SYNC0_FIRST && ref_v < V_SYNC0_FIRST + V_BLOCK_LEN) ||
                      (ref_v >= V_SYNC1_FIRST && ref_v < V_SYNC1_FIRST + V_BLOCK_LEN);
        in_act_blk  = (ref_v >= V_ACT0_FIRST && ref_v <= V_ACT0_LAST) ||
                      (ref_v >= V_ACT1_FIRST && ref_v <= V_ACT1_LAST);
        vid_active  = in_act_blk && ref_h >= H_ACT_FIRST && ref_h < H_ACT_FIRST + H_ACTIVE;
        burst_win   = in_act_blk && ref_h >= H_BURST_START && ref_h < H_BURST_END;
        // long pulses start every half-line inside the vertical sync block
        exp_sync_n  = in_sync_blk ? ((ref_h % H_HALF) >= H_VSYNC_PULSE_LEN) : (ref_h >= H_SYNC);
        // one register stage behind the column walk
        if (since_line >= 2 && since_line <= H_ACTIVE + 1) begin
            exp_rgb = tb_pal[tb_idx[(since_line - 2) / PIX_DIV]];
        end else begin
            exp_rgb = '0;
        end
    end

    // modulator outputs trail their inputs by one clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_luma      <= LUMA_SYNC;
            chroma_busy_d <= 1'b0;
        end else begin
            exp_luma      <= luma_level(rgb_sync_n, vid_active, rgb_r, rgb_g, rgb_b);
            chroma_busy_d <= vid_active || burst_win;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        frame_en && next_line |-> since_line == H_TOTAL)
        else note_mismatch(T_LINE, H_TOTAL, $sampled(since_line));
    assert property (@(posedge clk) disable iff (rst)
        frame_en |-> next_pixel == (since_line >= 1 && since_line <= H_ACTIVE))
        else note_mismatch(T_LINE, $sampled(since_line >= 1 && since_line <= H_ACTIVE),
                           $sampled(next_pixel));

    assert property (@(posedge clk) disable iff (rst)
        vblank_pulse && vb_count > 0 |-> since_vb == FIELD_CLKS)
        else note_mismatch(T_FIELD, FIELD_CLKS, $sampled(since_vb));
    assert property (@(posedge clk) disable iff (rst)
        vblank_pulse && vb_count > 0 |-> nf_between == 1)
        else note_mismatch(T_FIELD, 1, $sampled(nf_between));
    // the first strobe has no earlier parity to differ from
    assert property (@(posedge clk) disable iff (rst)
        next_frame && nf_count >= 1 |-> current_field != last_field)
        else note_mismatch(T_FIELD, !$sampled(last_field), $sampled(current_field));

    assert property (@(posedge clk) disable iff (rst)
        frame_en && (in_sync_blk || in_act_blk) |-> rgb_sync_n == exp_sync_n)
        else note_mismatch(T_SYNC, $sampled(exp_sync_n), $sampled(rgb_sync_n));

    assert property (@(posedge clk) disable iff (rst)
        frame_en |-> {rgb_r, rgb_g, rgb_b} == exp_rgb)
        else note_mismatch(T_PIXEL, $sampled(exp_rgb), $sampled({rgb_r, rgb_g, rgb_b}));

    assert property (@(posedge clk) disable iff (rst)
        frame_en |-> luma == exp_luma)
        else note_mismatch(T_LUMA, $sampled(exp_luma), $sampled(luma));

    assert property (@(posedge clk) disable iff (rst)
        frame_en && !chroma_busy_d |-> chroma == CHROMA_ZERO)
        else note_mismatch(T_CHROMA, CHROMA_ZERO, $sampled(chroma));

    task automatic write_palette();
        logic [3*RGB_W-1:0] colour;
        for (int i = 0; i < PAL_ENTRIES; i++) begin
            colour      = 12'($random(seed));
            tb_pal[i]   = colour;
            pal_wr_en   = 1'b1;
            pal_wr_addr = PAL_ADDR_W'(i);
            pal_wr_data = colour;
            @(negedge clk);
        end
        pal_wr_en = 1'b0;
    endtask

    task automatic write_line_buffer();
        logic [PAL_ADDR_W-1:0] index;
        for (int c = 0; c < LINE_PIXELS; c++) begin
            index        = PAL_ADDR_W'($random(seed));
            tb_idx[c]    = index;
            buf_wr_en    = 1'b1;
            buf_wr_addr  = PIX_ADDR_W'(c);
            buf_wr_index = index;
            @(negedge clk);
        end
        buf_wr_en = 1'b0;
    endtask

    // strobes are looked at on the falling edge, then one more clock lets the checks run
    task automatic wait_line();
        do @(negedge clk); while (!next_line);
        @(negedge clk);
    endtask

    task automatic wait_vblanks(input int n);
        repeat (n) begin
            do @(negedge clk); while (!vblank_pulse);
            @(negedge clk);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the second frame did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int failed;
        rst          = 1'b1;
        buf_wr_en    = 1'b0;
        buf_wr_addr  = '0;
        buf_wr_index = '0;
        pal_wr_en    = 1'b0;
        pal_wr_addr  = '0;
        pal_wr_data  = '0;
        frame_en     = 1'b0;
        seed         = 32'ha30540b6;
        failed       = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            errs[i] = 0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        write_palette();
        write_line_buffer();
        wait_line();
        // one full frame covers both fields
        frame_en = 1'b1;
        wait_vblanks(2);
        frame_en = 1'b0;
        report_test(T_LINE);
        report_test(T_SYNC);
        report_test(T_PIXEL);
        report_test(T_LUMA);
        report_test(T_CHROMA);
        wait_vblanks(2);
        report_test(T_FIELD);
        for (int i = 0; i < N_TESTS; i++) begin
            failed += (errs[i] != 0);
        end
        $display("tests %0d passed %0d failed %0d", N_TESTS, N_TESTS - failed, failed);
        if (failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/video_pkg.sv
video_composite/video_modulator.sv
video_composite/video_composite.sv
source/video_line_fetch.sv
source/video_top.sv
testbench/tb_video_top.sv

// ==== Bender.yml ====
package:
  name: video_composite

sources:
  - common/video_pkg.sv
  - video_composite/video_modulator.sv
  - video_composite/video_composite.sv
  - source/video_line_fetch.sv
  - source/video_top.sv
  - target: simulation
    files:
      - testbench/tb_video_top.sv
